// File: source/blur_pkg.sv
package blur_pkg;

    // window edge length of the smoothing kernel
    localparam int KERNEL_SIZE = 5;

    // 8-bit greyscale sample
    typedef logic [7:0] pixel_t;

    // weighted tap sum, worst case 255 * 159
    typedef logic [15:0] sum_t;

    // sum of the included kernel weights, at most 159
    typedef logic [7:0] weight_t;

    // one division job for the sequential divider
    typedef struct packed {
        sum_t    dividend;
        weight_t divisor;
    } div_request_t;

    // window engine states
    typedef enum logic [1:0] {
        PROLOGUE,
        FILTER,
        DIVIDE,
        OUTPUT
    } blur_state_t;

    // integer gaussian weights, row major, total 159
    localparam logic [0:KERNEL_SIZE-1][0:KERNEL_SIZE-1][3:0] GAUSS_KERNEL = '{
        '{4'd2, 4'd4,  4'd5,  4'd4,  4'd2},
        '{4'd4, 4'd9,  4'd12, 4'd9,  4'd4},
        '{4'd5, 4'd12, 4'd15, 4'd12, 4'd5},
        '{4'd4, 4'd9,  4'd12, 4'd9,  4'd4},
        '{4'd2, 4'd4,  4'd5,  4'd4,  4'd2}
    };

endpackage

// File: source/pixel_fifo.sv
`timescale 1ns/100ps

module pixel_fifo
    import blur_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   wr_en,
    input  pixel_t din,
    output logic   full,
    input  logic   rd_en,
    output pixel_t dout,
    output logic   empty
);

    localparam int ADDR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

    // storage ring
    pixel_t mem [FIFO_DEPTH];

    logic [ADDR_W-1:0]  wr_ptr_q;
    logic [ADDR_W-1:0]  rd_ptr_q;
    logic [COUNT_W-1:0] count_q;

    // accepted transfers only
    logic do_write;
    logic do_read;

    // pointer advance with wrap, depth need not be a power of two
    function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
        if (ptr == ADDR_W'(FIFO_DEPTH - 1)) begin
            next_ptr = '0;
        end else begin
            next_ptr = ptr + 1'b1;
        end
    endfunction

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // flags straight from the occupancy count
    assign full  = (count_q == COUNT_W'(FIFO_DEPTH));
    assign empty = (count_q == '0);

    // first word fall through, head visible without a read
    assign dout = mem[rd_ptr_q];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr_q] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_read) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // simultaneous push and pop leaves the count alone
            case ({do_write, do_read})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // producer must honour full
    a_no_write_when_full: assert property (@(posedge clock) disable iff (reset)
        wr_en |-> !full) else $error("pixel_fifo write while full");

    // consumer must honour empty
    a_no_read_when_empty: assert property (@(posedge clock) disable iff (reset)
        rd_en |-> !empty) else $error("pixel_fifo read while empty");

endmodule

// File: source/blur_divider.sv
`timescale 1ns/100ps

module blur_divider
    import blur_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         div_start,
    input  div_request_t request,
    output logic         div_done,
    output pixel_t       quotient
);

    // one quotient bit per dividend bit
    localparam int STEPS  = $bits(sum_t);
    localparam int CNT_W  = $clog2(STEPS);
    localparam int WGT_W  = $bits(weight_t);

    logic             busy_q;
    logic [CNT_W-1:0] count_q;

    // working registers
    weight_t divisor_q;
    weight_t rem_q;
    sum_t    quo_q;

    // operands of the current step
    weight_t step_divisor;
    weight_t step_rem;
    sum_t    step_quo;

    // remainder with the next dividend bit shifted in
    logic [WGT_W:0] partial;
    weight_t        next_rem;
    sum_t           next_quo;

    // first step runs straight off the request on the start cycle
    always_comb begin
        if (div_start) begin
            step_divisor = request.divisor;
            step_rem     = '0;
            step_quo     = request.dividend;
        end else begin
            step_divisor = divisor_q;
            step_rem     = rem_q;
            step_quo     = quo_q;
        end
        partial  = {step_rem, step_quo[STEPS-1]};
        next_quo = {step_quo[STEPS-2:0], 1'b0};
        // restoring step, subtract only when it fits
        if (partial >= {1'b0, step_divisor}) begin
            next_rem    = weight_t'(partial - {1'b0, step_divisor});
            next_quo[0] = 1'b1;
        end else begin
            next_rem = weight_t'(partial);
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy_q   <= 1'b0;
            count_q  <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                busy_q  <= 1'b1;
                count_q <= CNT_W'(1);
            end else if (busy_q) begin
                count_q <= count_q + 1'b1;
                // sixteenth step lands here
                if (count_q == CNT_W'(STEPS - 1)) begin
                    busy_q   <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (div_start) begin
            divisor_q <= request.divisor;
        end
        if (div_start || busy_q) begin
            rem_q <= next_rem;
            quo_q <= next_quo;
        end
    end

    // weighted average never exceeds one pixel
    assign quotient = quo_q[$bits(pixel_t)-1:0];

    a_divisor_nonzero: assert property (@(posedge clock) disable iff (reset)
        div_start |-> (request.divisor != '0)) else $error("blur_divider zero divisor");

    // only one pixel in flight
    a_no_start_busy: assert property (@(posedge clock) disable iff (reset)
        div_start |-> !busy_q) else $error("blur_divider start while busy");

endmodule

// File: source/gaussian_window.sv
`timescale 1ns/100ps

module gaussian_window
    import blur_pkg::*;
#(
    parameter int REDUCED_WIDTH  = 12,
    parameter int REDUCED_HEIGHT = 8,
    parameter int WIDTH          = 14,
    parameter int HEIGHT         = 10,
    parameter int STARTING_X     = 1,
    parameter int STARTING_Y     = 1
) (
    input  logic         clock,
    input  logic         reset,
    output logic         in_rd_en,
    input  logic         in_empty,
    input  pixel_t       in_dout,
    output logic         div_start,
    output div_request_t request,
    input  logic         div_done,
    input  pixel_t       quotient,
    output logic         out_wr_en,
    input  logic         out_full,
    output pixel_t       out_din
);

    // four rows plus five taps of history
    localparam int SHIFT_LEN    = 4 * REDUCED_WIDTH + 5;
    // pixels needed before pixel 0 sits in the window centre
    localparam int PROLOGUE_LEN = 2 * REDUCED_WIDTH + 3;
    localparam int PIXEL_COUNT  = REDUCED_WIDTH * REDUCED_HEIGHT;
    // first centre index whose next input lies past the region end
    localparam int PAD_START    = PIXEL_COUNT - PROLOGUE_LEN;
    localparam int COL_W        = $clog2(REDUCED_WIDTH);
    localparam int ROW_W        = $clog2(REDUCED_HEIGHT);
    localparam int CNT_W        = $clog2(PROLOGUE_LEN + 1);

    blur_state_t state_q;
    blur_state_t state_d;

    // index 0 holds the oldest pixel, newest enters at the top
    pixel_t [0:SHIFT_LEN-1] shift_q;

    // region coordinates of the current window centre
    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    logic [CNT_W-1:0] prologue_q;

    // set when the step in flight was the final pixel of the frame
    logic   last_q;
    pixel_t result_q;

    logic   padding;
    logic   shift_en;
    pixel_t shift_in;
    logic   step;
    logic   emit;
    logic   last_pixel;

    // per kernel column partial results
    sum_t    col_sum    [KERNEL_SIZE];
    weight_t col_weight [KERNEL_SIZE];
    sum_t    total_sum;
    weight_t total_weight;

    // tail of the frame, feed zeros instead of waiting on input
    assign padding = (int'(row_q) * REDUCED_WIDTH + int'(col_q)) >= PAD_START;

    // results only for centres two in from the top and left
    assign emit = step && (row_q >= ROW_W'(2)) && (col_q >= COL_W'(2));

    assign last_pixel = (row_q == ROW_W'(REDUCED_HEIGHT - 1)) &&
                        (col_q == COL_W'(REDUCED_WIDTH - 1));

    // input side and shift control
    always_comb begin
        in_rd_en = 1'b0;
        shift_en = 1'b0;
        shift_in = in_dout;
        step     = 1'b0;
        case (state_q)
            PROLOGUE: begin
                if (!in_empty) begin
                    in_rd_en = 1'b1;
                    shift_en = 1'b1;
                end
            end
            FILTER: begin
                // padding ignores a waiting next frame
                if (padding) begin
                    shift_en = 1'b1;
                    shift_in = '0;
                    step     = 1'b1;
                end else if (!in_empty) begin
                    in_rd_en = 1'b1;
                    shift_en = 1'b1;
                    step     = 1'b1;
                end
            end
            default: begin
                in_rd_en = 1'b0;
            end
        endcase
    end

    // 5x5 multiply accumulate, taps outside the full frame dropped
    always_comb begin
        int x;
        int y;
        for (int j = 0; j < KERNEL_SIZE; j++) begin
            col_sum[j]    = '0;
            col_weight[j] = '0;
        end
        for (int i = 0; i < KERNEL_SIZE; i++) begin
            for (int j = 0; j < KERNEL_SIZE; j++) begin
                // frame coordinates of this tap
                y = int'(row_q) + STARTING_Y + i - 2;
                x = int'(col_q) + STARTING_X + j - 2;
                if (x >= 0 && x < WIDTH && y >= 0 && y < HEIGHT) begin
                    col_sum[j] = col_sum[j] +
                        sum_t'(shift_q[i * REDUCED_WIDTH + j]) * sum_t'(GAUSS_KERNEL[i][j]);
                    col_weight[j] = col_weight[j] + weight_t'(GAUSS_KERNEL[i][j]);
                end
            end
        end
    end

    // fold the five columns together
    always_comb begin
        total_sum    = '0;
        total_weight = '0;
        for (int j = 0; j < KERNEL_SIZE; j++) begin
            total_sum    = total_sum + col_sum[j];
            total_weight = total_weight + col_weight[j];
        end
    end

    // division kicked off on the accumulating step
    assign div_start = emit;
    assign request   = '{dividend: total_sum, divisor: total_weight};

    // output side
    assign out_wr_en = (state_q == OUTPUT) && !out_full;
    assign out_din   = result_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            PROLOGUE: begin
                // move on with the last prologue pixel
                if (in_rd_en && prologue_q == CNT_W'(PROLOGUE_LEN - 1)) begin
                    state_d = FILTER;
                end
            end
            FILTER: begin
                if (emit) begin
                    state_d = DIVIDE;
                end
            end
            DIVIDE: begin
                if (div_done) begin
                    state_d = OUTPUT;
                end
            end
            OUTPUT: begin
                if (out_wr_en) begin
                    state_d = last_q ? PROLOGUE : FILTER;
                end
            end
            default: begin
                state_d = PROLOGUE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_q    <= PROLOGUE;
            col_q      <= '0;
            row_q      <= '0;
            prologue_q <= '0;
            last_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == PROLOGUE && in_rd_en) begin
                prologue_q <= prologue_q + 1'b1;
            end
            if (step) begin
                last_q <= last_pixel;
                // raster advance, wraps to 0,0 after the final pixel
                if (col_q == COL_W'(REDUCED_WIDTH - 1)) begin
                    col_q <= '0;
                    if (row_q == ROW_W'(REDUCED_HEIGHT - 1)) begin
                        row_q <= '0;
                    end else begin
                        row_q <= row_q + 1'b1;
                    end
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
            // frame finished, start over
            if (out_wr_en && last_q) begin
                prologue_q <= '0;
                last_q     <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (shift_en) begin
            shift_q <= {shift_q[1:SHIFT_LEN-1], shift_in};
        end
        // hold the quotient until the output FIFO takes it
        if (div_done) begin
            result_q <= quotient;
        end
    end

    // the divider answers only while the engine waits on it
    a_done_in_divide: assert property (@(posedge clock) disable iff (reset)
        div_done |-> (state_q == DIVIDE))
        else $error("gaussian_window div_done outside DIVIDE");

    // fixed sixteen cycle divider latency
    a_divide_latency: assert property (@(posedge clock) disable iff (reset)
        div_start |-> ##16 div_done)
        else $error("gaussian_window divider latency not 16 cycles");

endmodule

// File: source/blur_top.sv
`timescale 1ns/100ps

module blur_top
    import blur_pkg::*;
#(
    parameter int REDUCED_WIDTH  = 12,
    parameter int REDUCED_HEIGHT = 8,
    parameter int WIDTH          = 14,
    parameter int HEIGHT         = 10,
    parameter int STARTING_X     = 1,
    parameter int STARTING_Y     = 1,
    parameter int FIFO_DEPTH     = 8
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   in_wr_en,
    input  pixel_t in_din,
    output logic   in_full,
    input  logic   out_rd_en,
    output pixel_t out_dout,
    output logic   out_empty
);

    // input FIFO to engine
    logic   in_rd_en;
    logic   in_empty;
    pixel_t in_dout;

    // engine to divider and back
    logic         div_start;
    div_request_t div_request;
    logic         div_done;
    pixel_t       quotient;

    // engine to output FIFO
    logic   out_wr_en;
    logic   out_full;
    pixel_t out_din;

    // raster pixels from the camera side
    pixel_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_in_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (in_rd_en),
        .dout  (in_dout),
        .empty (in_empty)
    );

    gaussian_window #(
        .REDUCED_WIDTH  (REDUCED_WIDTH),
        .REDUCED_HEIGHT (REDUCED_HEIGHT),
        .WIDTH          (WIDTH),
        .HEIGHT         (HEIGHT),
        .STARTING_X     (STARTING_X),
        .STARTING_Y     (STARTING_Y)
    ) u_gaussian_window (
        .clock     (clock),
        .reset     (reset),
        .in_rd_en  (in_rd_en),
        .in_empty  (in_empty),
        .in_dout   (in_dout),
        .div_start (div_start),
        .request   (div_request),
        .div_done  (div_done),
        .quotient  (quotient),
        .out_wr_en (out_wr_en),
        .out_full  (out_full),
        .out_din   (out_din)
    );

    // weighted sum over weight total
    blur_divider u_blur_divider (
        .clock     (clock),
        .reset     (reset),
        .div_start (div_start),
        .request   (div_request),
        .div_done  (div_done),
        .quotient  (quotient)
    );

    // smoothed pixels towards the next stage
    pixel_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (out_wr_en),
        .din   (out_din),
        .full  (out_full),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .empty (out_empty)
    );

endmodule

// File: tests/blur_model.svh
`ifndef BLUR_MODEL_SVH
`define BLUR_MODEL_SVH

// expected results of one stored region frame, pushed onto expected_q

// linear region index, wraps into the neighbouring row
function automatic pixel_t tap_value(input pixel_t img [FRAME_PIXELS], input int index);
    // past the region end the stream is zero padded
    if (index < 0 || index >= FRAME_PIXELS) begin
        return '0;
    end
    return img[index];
endfunction

// floor of the weighted average over the taps inside the full frame
function automatic pixel_t smoothed_pixel(input pixel_t img [FRAME_PIXELS],
                                          input int r, input int c);
    int sum;
    int weight;
    int x;
    int y;
    int k;
    sum    = 0;
    weight = 0;
    for (int i = -2; i <= 2; i++) begin
        for (int j = -2; j <= 2; j++) begin
            // full frame position of this tap
            x = c + j + STARTING_X;
            y = r + i + STARTING_Y;
            if (x >= 0 && x < WIDTH && y >= 0 && y < HEIGHT) begin
                k      = int'(GAUSS_KERNEL[i + 2][j + 2]);
                sum    = sum + k * int'(tap_value(img, (r + i) * REDUCED_WIDTH + c + j));
                weight = weight + k;
            end
        end
    end
    // centre tap is always inside for sane geometries
    if (weight == 0) begin
        return '0;
    end
    return pixel_t'(sum / weight);
endfunction

// raster order, two rows and two columns in from the top left
task automatic model_frame(input pixel_t img [FRAME_PIXELS]);
    for (int r = 2; r < REDUCED_HEIGHT; r++) begin
        for (int c = 2; c < REDUCED_WIDTH; c++) begin
            expected_q.push_back(smoothed_pixel(img, r, c));
        end
    end
endtask

`endif

// File: tests/blur_tb.sv
`timescale 1ns/100ps

module blur_tb
    import blur_pkg::*;
();

    // small geometry, right column taps leave the frame
    localparam int REDUCED_WIDTH  = 12;
    localparam int REDUCED_HEIGHT = 8;
    localparam int WIDTH          = 14;
    localparam int HEIGHT         = 10;
    localparam int STARTING_X     = 1;
    localparam int STARTING_Y     = 1;
    localparam int FIFO_DEPTH     = 8;
    localparam int FRAME_PIXELS   = REDUCED_WIDTH * REDUCED_HEIGHT;
    localparam int PER_FRAME      = (REDUCED_WIDTH - 2) * (REDUCED_HEIGHT - 2);
    // frames over all tests
    localparam int TOTAL_FRAMES   = 5;
    localparam int CYCLE_LIMIT    = 4 * (TOTAL_FRAMES * FRAME_PIXELS * 20);

    logic   clock;
    logic   reset;
    logic   in_wr_en;
    pixel_t in_din;
    logic   in_full;
    logic   out_rd_en;
    pixel_t out_dout;
    logic   out_empty;

    integer seed;
    int     cycles;
    int     errors;
    int     tests_run;
    int     tests_failed;
    logic   saw_full;
    int     frame_counts [2];
    pixel_t frame [FRAME_PIXELS];
    // pixels still to write, results still to see
    pixel_t stim_q [$];
    pixel_t expected_q [$];

    `include "blur_model.svh"

    blur_top #(
        .REDUCED_WIDTH  (REDUCED_WIDTH),
        .REDUCED_HEIGHT (REDUCED_HEIGHT),
        .WIDTH          (WIDTH),
        .HEIGHT         (HEIGHT),
        .STARTING_X     (STARTING_X),
        .STARTING_Y     (STARTING_Y),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) u_blur_top (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // hang guard
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, results still missing", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic compare_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_frame_count(input int index, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("MISMATCH at %0t: results of frame %0d got %0d expected %0d",
                     $time, index, got, exp);
        end
    endtask

    // one stored frame, into the write queue and the model
    task automatic make_frame(input bit all_max);
        for (int p = 0; p < FRAME_PIXELS; p++) begin
            frame[p] = all_max ? 8'd255 : pixel_t'($random(seed));
            stim_q.push_back(frame[p]);
        end
        model_frame(frame);
    endtask

    // writer side, full is stable at the falling edge
    task automatic write_pixels(input int idle_chance);
        while (stim_q.size() > 0) begin
            @(negedge clock);
            if (in_full) begin
                saw_full = 1'b1;
            end
            if (in_full || ({$random(seed)} % 100) < idle_chance) begin
                in_wr_en = 1'b0;
            end else begin
                in_wr_en = 1'b1;
                in_din   = stim_q.pop_front();
            end
        end
        @(negedge clock);
        in_wr_en = 1'b0;
    endtask

    // reader side with an opening stall and random stall bursts
    task automatic read_results(input int total, input int first_stall, input int stall_chance);
        int     received;
        int     stall;
        pixel_t exp_px;
        received = 0;
        stall    = first_stall;
        while (received < total) begin
            @(negedge clock);
            out_rd_en = 1'b0;
            if (stall > 0) begin
                stall--;
            end else if (({$random(seed)} % 100) < stall_chance) begin
                stall = {$random(seed)} % 40;
            end else if (!out_empty) begin
                out_rd_en = 1'b1;
                exp_px    = expected_q.pop_front();
                compare_pixel("out_dout", out_dout, exp_px);
                frame_counts[received / PER_FRAME]++;
                received++;
            end
        end
        // anything that still shows up counts against the last frame
        repeat (60) begin
            @(negedge clock);
            out_rd_en = 1'b0;
            if (!out_empty) begin
                out_rd_en = 1'b1;
                frame_counts[(total - 1) / PER_FRAME]++;
            end
        end
        @(negedge clock);
        out_rd_en = 1'b0;
    endtask

    task automatic run_test(input string name, input int nframes, input bit second_max,
                            input int idle_chance, input int first_stall,
                            input int stall_chance, input bit expect_full);
        int errors_before;
        errors_before = errors;
        saw_full      = 1'b0;
        stim_q.delete();
        expected_q.delete();
        for (int f = 0; f < nframes; f++) begin
            frame_counts[f] = 0;
            make_frame(second_max && f == 1);
        end
        fork
            write_pixels(idle_chance);
            read_results(expected_q.size(), first_stall, stall_chance);
        join
        for (int f = 0; f < nframes; f++) begin
            check_frame_count(f, frame_counts[f], PER_FRAME);
        end
        // back-pressure must reach the input side
        if (expect_full) begin
            compare_flag("in_full seen", saw_full, 1'b1);
        end
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, (errors == errors_before) ? "ok" : "bad");
    endtask

    initial begin
        seed         = 37;
        cycles       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        saw_full     = 1'b0;
        reset        = 1'b1;
        in_wr_en     = 1'b0;
        in_din       = '0;
        out_rd_en    = 1'b0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // flags straight out of reset
        @(negedge clock);
        compare_flag("out_empty", out_empty, 1'b1);
        compare_flag("in_full", in_full, 1'b0);
        tests_run++;
        if (errors != 0) begin
            tests_failed++;
        end
        $display("test %0d reset flags: %s", tests_run, (errors == 0) ? "ok" : "bad");

        run_test("single frame", 1, 1'b0, 0, 0, 0, 1'b0);
        run_test("input gaps", 1, 1'b0, 40, 0, 0, 1'b0);
        run_test("output stalls", 1, 1'b0, 0, 400, 5, 1'b1);
        run_test("two frames", 2, 1'b1, 0, 0, 0, 1'b0);

        $display("done: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+tests
source/blur_pkg.sv
source/pixel_fifo.sv
source/blur_divider.sv
source/gaussian_window.sv
source/blur_top.sv
tests/blur_tb.sv

// File: Makefile
# Verilator build and run for the gaussian smoothing stage

SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = blur_tb
FILELIST = filelist.f

BUILD   = obj_dir
BINARY  = $(BUILD)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST)) tests/blur_model.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the pass line in the log decides the result
run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
